//--- rtl/lsu_pkg.sv
package lsu_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    typedef logic [31:0] xlen_t;
    typedef logic [3:0]  rob_idx_t;
    typedef logic [5:0]  phys_reg_t;
    typedef logic [4:0]  arch_reg_t;
    typedef logic [3:0]  byte_mask_t;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    localparam int LSQ_DEPTH   = 8;
    localparam int LSQ_IDX     = $clog2(LSQ_DEPTH);
    localparam int MEM_WORDS   = 64;
    localparam int MEM_LATENCY = 2;
    localparam int MEM_ADDR_W  = $clog2(MEM_WORDS);

    // Bit 3 marks a store, bit 2 unsigned, bits 1:0 give the size
    typedef enum logic [3:0] {
        MEM_LB  = 4'b0000,
        MEM_LH  = 4'b0001,
        MEM_LW  = 4'b0010,
        MEM_LBU = 4'b0100,
        MEM_LHU = 4'b0101,
        MEM_SB  = 4'b1000,
        MEM_SH  = 4'b1001,
        MEM_SW  = 4'b1010
    } mem_op_e;

    //////////////////////////////////////////////////
    // Interface structs
    //////////////////////////////////////////////////

    typedef struct packed {
        rob_idx_t  rob_id;
        mem_op_e   op;
        arch_reg_t rd_arch;
        phys_reg_t rd_phy;
    } ls_dispatch_t;

    typedef struct packed {
        rob_idx_t rob_id;
        mem_op_e  op;
        xlen_t    base;
        xlen_t    offset;
        xlen_t    store_value;
    } agu_req_t;

    typedef struct packed {
        rob_idx_t   rob_id;
        xlen_t      addr;
        byte_mask_t mask;
        xlen_t      wdata;
    } agu_resp_t;

    // Word address, not byte address
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] addr;
        logic                  write;
        byte_mask_t            mask;
        xlen_t                 wdata;
    } mem_cmd_t;

    typedef struct packed {
        rob_idx_t  rob_id;
        phys_reg_t rd_phy;
        arch_reg_t rd_arch;
        xlen_t     value;
    } cdb_t;

endpackage

//--- rtl/lsu_agu.sv
`timescale 1ns/1ps

module lsu_agu
import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      agu_valid,
    input  agu_req_t  agu_in,
    output logic      agu_out_valid,
    output agu_resp_t agu_out
);

    xlen_t      eff_addr;
    byte_mask_t lane_mask;
    xlen_t      lane_data;

    assign eff_addr = agu_in.base + agu_in.offset;

    //////////////////////////////////////////////////
    // Byte lanes
    //////////////////////////////////////////////////

    always_comb begin
        case (agu_in.op[1:0])
            2'b00: begin
                lane_mask = byte_mask_t'(4'b0001 << eff_addr[1:0]);
            end
            2'b01: begin
                lane_mask = byte_mask_t'(4'b0011 << {eff_addr[1], 1'b0});
            end
            default: begin
                lane_mask = 4'b1111;
            end
        endcase
    end

    // Store value moved up to its lane, unused bytes are masked off
    assign lane_data = agu_in.store_value << {eff_addr[1:0], 3'b000};

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            agu_out_valid <= 1'b0;
        end else begin
            agu_out_valid <= agu_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (agu_valid) begin
            agu_out.rob_id <= agu_in.rob_id;
            agu_out.addr   <= eff_addr;
            agu_out.mask   <= lane_mask;
            agu_out.wdata  <= lane_data;
        end
    end

    // Halfwords on even bytes, words on word boundaries
    assert property (@(posedge clk) disable iff (rst)
        agu_valid |-> (agu_in.op[1:0] == 2'b00)
                   || (agu_in.op[1:0] == 2'b01 && !eff_addr[0])
                   || (eff_addr[1:0] == 2'b00))
        else $error("lsu_agu: misaligned access at %h", eff_addr);

endmodule

//--- rtl/lsu_queue.sv
`timescale 1ns/1ps

module lsu_queue
import lsu_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         backend_flush,
    input  logic         dispatch_valid,
    input  ls_dispatch_t dispatch,
    output logic         dispatch_ready,
    input  logic         agu_out_valid,
    input  agu_resp_t    agu_out,
    input  rob_idx_t     rob_head,
    output logic         mem_req,
    output mem_cmd_t     mem_cmd,
    input  logic         mem_ack,
    input  xlen_t        mem_rdata,
    output logic         cdb_valid,
    output cdb_t         cdb
);

    typedef struct packed {
        rob_idx_t   rob_id;
        mem_op_e    op;
        arch_reg_t  rd_arch;
        phys_reg_t  rd_phy;
        logic       ready;
        xlen_t      addr;
        byte_mask_t mask;
        xlen_t      wdata;
    } lsq_entry_t;

    typedef enum logic [1:0] {IDLE, REQ, RELEASE} hs_state_e;

    lsq_entry_t           fifo [LSQ_DEPTH];
    lsq_entry_t           head;

    logic [LSQ_IDX:0]     wr_ptr;
    logic [LSQ_IDX:0]     rd_ptr;
    logic [LSQ_IDX-1:0]   wr_idx;
    logic [LSQ_IDX-1:0]   rd_idx;
    logic [LSQ_IDX:0]     count;
    logic [LSQ_DEPTH-1:0] live;
    logic                 full;
    logic                 empty;
    logic                 enqueue;
    logic                 dequeue;

    logic                 issuable;
    logic                 start;
    hs_state_e            state;
    logic                 flushed;

    logic [7:0]           byte_lane;
    logic [15:0]          half_lane;
    xlen_t                load_value;

    //////////////////////////////////////////////////
    // Pointers
    //////////////////////////////////////////////////

    assign wr_idx = wr_ptr[LSQ_IDX-1:0];
    assign rd_idx = rd_ptr[LSQ_IDX-1:0];
    assign count  = wr_ptr - rd_ptr;
    assign full   = (wr_idx == rd_idx) && (wr_ptr[LSQ_IDX] != rd_ptr[LSQ_IDX]);
    assign empty  = (wr_ptr == rd_ptr);

    assign dispatch_ready = !full;
    assign enqueue        = dispatch_valid && dispatch_ready;

    always_ff @(posedge clk) begin
        if (rst || backend_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (enqueue) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (dequeue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Slot is live when it sits between head and tail
    always_comb begin
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            live[i] = {1'b0, (LSQ_IDX)'(i - rd_idx)} < count;
        end
    end

    //////////////////////////////////////////////////
    // Entries
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (agu_out_valid) begin
            for (int i = 0; i < LSQ_DEPTH; i++) begin
                if (live[i] && fifo[i].rob_id == agu_out.rob_id) begin
                    fifo[i].ready <= 1'b1;
                    fifo[i].addr  <= agu_out.addr;
                    fifo[i].mask  <= agu_out.mask;
                    fifo[i].wdata <= agu_out.wdata;
                end
            end
        end
        if (enqueue) begin
            fifo[wr_idx].rob_id  <= dispatch.rob_id;
            fifo[wr_idx].op      <= dispatch.op;
            fifo[wr_idx].rd_arch <= dispatch.rd_arch;
            fifo[wr_idx].rd_phy  <= dispatch.rd_phy;
            fifo[wr_idx].ready   <= 1'b0;
        end
    end

    assign head = fifo[rd_idx];

    // Stores wait for the ROB to reach them
    assign issuable = !empty && head.ready && (!head.op[3] || rob_head == head.rob_id);
    assign start    = issuable && !mem_ack && !backend_flush && (state != REQ);

    //////////////////////////////////////////////////
    // Memory handshake
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            mem_req <= 1'b0;
            flushed <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= REQ;
                        mem_req <= 1'b1;
                        flushed <= 1'b0;
                    end
                end
                REQ: begin
                    if (backend_flush) begin
                        flushed <= 1'b1;
                    end
                    if (mem_ack) begin
                        state   <= RELEASE;
                        mem_req <= 1'b0;
                    end
                end
                RELEASE: begin
                    // Back to back issue once ack has fallen
                    if (start) begin
                        state   <= REQ;
                        mem_req <= 1'b1;
                        flushed <= 1'b0;
                    end else if (!mem_ack) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mem_cmd.addr  <= head.addr[MEM_ADDR_W+1:2];
            mem_cmd.write <= head.op[3];
            mem_cmd.mask  <= head.mask;
            mem_cmd.wdata <= head.wdata;
        end
    end

    //////////////////////////////////////////////////
    // Load extension and CDB
    //////////////////////////////////////////////////

    assign byte_lane = mem_rdata[8*head.addr[1:0] +: 8];
    assign half_lane = mem_rdata[16*head.addr[1] +: 16];

    always_comb begin
        case (head.op)
            MEM_LB:  load_value = {{24{byte_lane[7]}}, byte_lane};
            MEM_LBU: load_value = {24'b0, byte_lane};
            MEM_LH:  load_value = {{16{half_lane[15]}}, half_lane};
            MEM_LHU: load_value = {16'b0, half_lane};
            MEM_LW:  load_value = mem_rdata;
            default: load_value = '0;
        endcase
    end

    assign cdb_valid = (state == REQ) && mem_ack && !flushed && !backend_flush;
    assign dequeue   = cdb_valid;

    assign cdb.rob_id  = head.rob_id;
    assign cdb.rd_phy  = head.rd_phy;
    assign cdb.rd_arch = head.rd_arch;
    assign cdb.value   = load_value;

    // Occupancy never runs past the depth or below zero
    assert property (@(posedge clk) disable iff (rst)
        count <= (LSQ_IDX+1)'(LSQ_DEPTH))
        else $error("lsu_queue: enqueue while full");

    assert property (@(posedge clk) disable iff (rst)
        mem_req |=> !mem_req || $stable(mem_cmd))
        else $error("lsu_queue: mem_cmd changed during request");

endmodule

//--- rtl/lsu_data_mem.sv
`timescale 1ns/1ps

module lsu_data_mem
import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     mem_req,
    input  mem_cmd_t mem_cmd,
    output logic     mem_ack,
    output xlen_t    mem_rdata
);

    typedef enum logic [1:0] {WAIT_REQ, ACCESS, WAIT_DROP} mem_state_e;
    typedef logic [$clog2(MEM_LATENCY+1)-1:0] lat_cnt_t;

    xlen_t      mem [MEM_WORDS];
    mem_state_e state;
    lat_cnt_t   lat_cnt;
    logic       access_done;

    // Last cycle of the access, ack follows on the next edge
    assign access_done = (state == ACCESS) && (lat_cnt == lat_cnt_t'(MEM_LATENCY - 1));

    //////////////////////////////////////////////////
    // Handshake FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= WAIT_REQ;
            lat_cnt <= '0;
            mem_ack <= 1'b0;
        end else begin
            case (state)
                WAIT_REQ: begin
                    if (mem_req) begin
                        state   <= ACCESS;
                        lat_cnt <= lat_cnt_t'(1);
                    end
                end
                ACCESS: begin
                    if (access_done) begin
                        state   <= WAIT_DROP;
                        mem_ack <= 1'b1;
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end
                WAIT_DROP: begin
                    if (!mem_req) begin
                        state   <= WAIT_REQ;
                        mem_ack <= 1'b0;
                    end
                end
                default: begin
                    state <= WAIT_REQ;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (access_done) begin
            mem_rdata <= mem[mem_cmd.addr];
            if (mem_cmd.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem_cmd.mask[b]) begin
                        mem[mem_cmd.addr][8*b +: 8] <= mem_cmd.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> mem_req)
        else $error("lsu_data_mem: request dropped before ack");

endmodule

//--- rtl/lsu_top.sv
`timescale 1ns/1ps

module lsu_top
import lsu_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         backend_flush,
    input  logic         dispatch_valid,
    input  ls_dispatch_t dispatch,
    output logic         dispatch_ready,
    input  logic         agu_valid,
    input  agu_req_t     agu_in,
    input  rob_idx_t     rob_head,
    output logic         cdb_valid,
    output cdb_t         cdb
);

    logic      agu_out_valid;
    agu_resp_t agu_out;
    logic      mem_req;
    mem_cmd_t  mem_cmd;
    logic      mem_ack;
    xlen_t     mem_rdata;

    lsu_agu u_agu (
        .clk           (clk),
        .rst           (rst),
        .agu_valid     (agu_valid),
        .agu_in        (agu_in),
        .agu_out_valid (agu_out_valid),
        .agu_out       (agu_out)
    );

    lsu_queue u_queue (
        .clk            (clk),
        .rst            (rst),
        .backend_flush  (backend_flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .agu_out_valid  (agu_out_valid),
        .agu_out        (agu_out),
        .rob_head       (rob_head),
        .mem_req        (mem_req),
        .mem_cmd        (mem_cmd),
        .mem_ack        (mem_ack),
        .mem_rdata      (mem_rdata),
        .cdb_valid      (cdb_valid),
        .cdb            (cdb)
    );

    lsu_data_mem u_data_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

//--- testbench/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu
import lsu_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    logic         clk = 1'b0;
    logic         rst;
    logic         backend_flush;
    logic         dispatch_valid;
    ls_dispatch_t dispatch;
    logic         dispatch_ready;
    logic         agu_valid;
    agu_req_t     agu_in;
    rob_idx_t     rob_head = '0;
    logic         cdb_valid;
    cdb_t         cdb;

    // Reference state, owned by the scoreboard block
    logic [7:0]   model [MEM_WORDS*4];
    xlen_t        op_addr [16];
    xlen_t        op_value [16];
    ls_dispatch_t rec_q [$];
    logic [15:0]  flushed_ids;
    logic         exp_valid;
    logic         exp_load;
    rob_idx_t     exp_rob;
    arch_reg_t    exp_arch;
    phys_reg_t    exp_phy;
    xlen_t        exp_value;
    int           pending;

    logic         rob_follow;
    rob_idx_t     rob_hold;
    logic         expect_full;
    string        test_name = "reset";
    int           seed = 95537;
    int           next_rob = 0;
    int           value_errs = 0;
    int           other_errs = 0;
    int           timeouts = 0;

    lsu_top DUT (
        .clk            (clk),
        .rst            (rst),
        .backend_flush  (backend_flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .agu_valid      (agu_valid),
        .agu_in         (agu_in),
        .rob_head       (rob_head),
        .cdb_valid      (cdb_valid),
        .cdb            (cdb)
    );

    always #4 clk = ~clk;

    // ROB head either tracks the oldest op or is parked
    always @(posedge clk) begin
        #1;
        rob_head = rob_follow ? exp_rob : rob_hold;
    end

    function automatic logic is_store(mem_op_e op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

    function automatic int op_bytes(mem_op_e op);
        case (op)
            MEM_LB, MEM_LBU, MEM_SB: return 1;
            MEM_LH, MEM_LHU, MEM_SH: return 2;
            default: return 4;
        endcase
    endfunction

    // Little endian read of the byte model
    function automatic xlen_t model_load(mem_op_e op, xlen_t addr);
        logic [7:0]  a;
        logic [15:0] h;
        a = addr[7:0];
        h = {model[a + 8'd1], model[a]};
        case (op)
            MEM_LB:  return {{24{model[a][7]}}, model[a]};
            MEM_LBU: return {24'b0, model[a]};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'b0, h};
            default: return {model[a + 8'd3], model[a + 8'd2], h};
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Scoreboard
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        ls_dispatch_t front;
        xlen_t        st_addr;
        if (rst) begin
            rec_q.delete();
            flushed_ids <= '0;
            exp_valid   <= 1'b0;
            pending     <= 0;
        end else begin
            if (agu_valid) begin
                op_addr[agu_in.rob_id]  = agu_in.base + agu_in.offset;
                op_value[agu_in.rob_id] = agu_in.store_value;
            end
            if (cdb_valid && rec_q.size() > 0) begin
                front = rec_q.pop_front();
                if (is_store(front.op)) begin
                    st_addr = op_addr[front.rob_id];
                    for (int i = 0; i < op_bytes(front.op); i++) begin
                        model[st_addr[7:0] + 8'(i)] = op_value[front.rob_id][8*i +: 8];
                    end
                end
            end
            if (dispatch_valid && dispatch_ready) begin
                rec_q.push_back(dispatch);
                flushed_ids[dispatch.rob_id] <= 1'b0;
            end
            if (backend_flush) begin
                foreach (rec_q[i]) begin
                    flushed_ids[rec_q[i].rob_id] <= 1'b1;
                end
                rec_q.delete();
            end
            if (rec_q.size() > 0) begin
                front = rec_q[0];
                exp_valid <= 1'b1;
                exp_load  <= !is_store(front.op);
                exp_rob   <= front.rob_id;
                exp_arch  <= front.rd_arch;
                exp_phy   <= front.rd_phy;
                exp_value <= model_load(front.op, op_addr[front.rob_id]);
            end else begin
                exp_valid <= 1'b0;
            end
            pending <= rec_q.size();
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst) cdb_valid |-> exp_valid)
        else begin
            other_errs++;
            $display("%s: CDB pulse for rob %0d with no op outstanding",
                     test_name, $sampled(cdb.rob_id));
        end

    assert property (@(posedge clk) disable iff (rst)
        cdb_valid && exp_valid |-> cdb.rob_id == exp_rob)
        else begin
            value_errs++;
            $display("ERR %s rob_id expected %0d actual %0d",
                     test_name, $sampled(exp_rob), $sampled(cdb.rob_id));
        end

    assert property (@(posedge clk) disable iff (rst)
        cdb_valid && exp_valid |-> cdb.rd_phy == exp_phy && cdb.rd_arch == exp_arch)
        else begin
            value_errs++;
            $display("ERR %s rd expected p%0d/x%0d actual p%0d/x%0d", test_name,
                     $sampled(exp_phy), $sampled(exp_arch),
                     $sampled(cdb.rd_phy), $sampled(cdb.rd_arch));
        end

    assert property (@(posedge clk) disable iff (rst)
        cdb_valid && exp_valid && exp_load |-> cdb.value == exp_value)
        else begin
            value_errs++;
            $display("ERR %s value expected %h actual %h",
                     test_name, $sampled(exp_value), $sampled(cdb.value));
        end

    assert property (@(posedge clk) disable iff (rst)
        cdb_valid && exp_valid && !exp_load |-> rob_head == cdb.rob_id)
        else begin
            other_errs++;
            $display("%s: store rob %0d completed while the ROB head was %0d",
                     test_name, $sampled(cdb.rob_id), $sampled(rob_head));
        end

    assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> !flushed_ids[cdb.rob_id])
        else begin
            other_errs++;
            $display("%s: flushed rob %0d still reached the CDB",
                     test_name, $sampled(cdb.rob_id));
        end

    assert property (@(posedge clk) disable iff (rst) expect_full |-> !dispatch_ready)
        else begin
            other_errs++;
            $display("%s: dispatch_ready high with the queue full", test_name);
        end

    //////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    // Ready is looked at mid cycle, so the next edge is the transfer
    task automatic send_dispatch(input rob_idx_t rob, input mem_op_e op);
        int waited;
        waited = 0;
        dispatch_valid   = 1'b1;
        dispatch.rob_id  = rob;
        dispatch.op      = op;
        dispatch.rd_arch = arch_reg_t'($random(seed));
        dispatch.rd_phy  = phys_reg_t'($random(seed));
        while (!dispatch_ready && waited < WAIT_LIMIT) begin
            waited++;
            step_cycle();
        end
        if (!dispatch_ready) begin
            timeouts++;
            $display("%s: dispatch of rob %0d was never accepted", test_name, rob);
        end
        step_cycle();
        dispatch_valid = 1'b0;
    endtask

    task automatic send_agu(input rob_idx_t rob, input mem_op_e op, input xlen_t addr,
                            input xlen_t value);
        xlen_t offset;
        offset = xlen_t'($random(seed) % 64);
        agu_valid          = 1'b1;
        agu_in.rob_id      = rob;
        agu_in.op          = op;
        agu_in.base        = addr - offset;
        agu_in.offset      = offset;
        agu_in.store_value = value;
        step_cycle();
        agu_valid = 1'b0;
    endtask

    task automatic run_op(input mem_op_e op, input xlen_t addr, input xlen_t value);
        rob_idx_t rob;
        rob = rob_idx_t'(next_rob);
        next_rob++;
        send_dispatch(rob, op);
        send_agu(rob, op, addr, value);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending != 0 && waited < WAIT_LIMIT) begin
            step_cycle();
            waited++;
        end
        if (pending != 0) begin
            timeouts++;
            $display("%s: %0d ops never completed on the CDB", test_name, pending);
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        xlen_t    addr_list [8];
        mem_op_e  ops [6];
        xlen_t    addrs [6];
        rob_idx_t robs [LSQ_DEPTH];
        int       perm [6];
        int       j;
        int       tmp;
        int       waited;

        rst            = 1'b1;
        backend_flush  = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        agu_valid      = 1'b0;
        agu_in         = '0;
        rob_follow     = 1'b0;
        rob_hold       = '0;
        expect_full    = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        test_name  = "store_load_word";
        rob_follow = 1'b1;
        for (int i = 0; i < 8; i++) begin
            addr_list[i] = xlen_t'($unsigned($random(seed)) % MEM_WORDS) << 2;
            run_op(MEM_SW, addr_list[i], $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            run_op(MEM_LW, addr_list[i], '0);
        end
        wait_drain();

        // One fixed word so both signs show up in every lane
        test_name = "subword_extend";
        run_op(MEM_SW, 32'h40, 32'h80ff7f01);
        run_op(MEM_SW, 32'h44, $random(seed));
        for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < 4; b++) begin
                run_op(MEM_LB, xlen_t'(32'h40 + 4*w + b), '0);
                run_op(MEM_LBU, xlen_t'(32'h40 + 4*w + b), '0);
                if (b % 2 == 0) begin
                    run_op(MEM_LH, xlen_t'(32'h40 + 4*w + b), '0);
                    run_op(MEM_LHU, xlen_t'(32'h40 + 4*w + b), '0);
                end
            end
        end
        wait_drain();

        test_name  = "order_commit";
        rob_hold   = rob_idx_t'(next_rob + 8);
        rob_follow = 1'b0;
        ops   = '{MEM_SW, MEM_LW, MEM_SH, MEM_LHU, MEM_SB, MEM_LB};
        addrs = '{addr_list[0], addr_list[0], addr_list[1] + 2, addr_list[1] + 2,
                  addr_list[2] + 1, addr_list[2] + 1};
        for (int i = 0; i < 6; i++) begin
            robs[i] = rob_idx_t'(next_rob);
            next_rob++;
            perm[i] = i;
            send_dispatch(robs[i], ops[i]);
        end
        for (int i = 5; i > 0; i--) begin
            j       = $unsigned($random(seed)) % (i + 1);
            tmp     = perm[i];
            perm[i] = perm[j];
            perm[j] = tmp;
        end
        for (int i = 0; i < 6; i++) begin
            send_agu(robs[perm[i]], ops[perm[i]], addrs[perm[i]], $random(seed));
        end
        // Store at the head stays parked while the ROB points elsewhere
        repeat (20) step_cycle();
        rob_follow = 1'b1;
        wait_drain();

        test_name = "full_backpressure";
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            robs[i] = rob_idx_t'(next_rob);
            next_rob++;
            send_dispatch(robs[i], MEM_LW);
        end
        expect_full = 1'b1;
        repeat (3) step_cycle();
        expect_full = 1'b0;
        send_agu(robs[0], MEM_LW, addr_list[0], '0);
        waited = 0;
        while (!dispatch_ready && waited < WAIT_LIMIT) begin
            step_cycle();
            waited++;
        end
        if (!dispatch_ready) begin
            timeouts++;
            $display("%s: dispatch_ready stayed low after a completion", test_name);
        end
        for (int i = 1; i < LSQ_DEPTH; i++) begin
            send_agu(robs[i], MEM_LW, addr_list[i], '0);
        end
        wait_drain();

        test_name = "flush";
        for (int i = 0; i < 4; i++) begin
            robs[i] = rob_idx_t'(next_rob);
            next_rob++;
            send_dispatch(robs[i], (i == 2) ? MEM_SW : MEM_LW);
        end
        send_agu(robs[0], MEM_LW, addr_list[3], '0);
        waited = 0;
        while (!DUT.mem_req && waited < WAIT_LIMIT) begin
            step_cycle();
            waited++;
        end
        if (!DUT.mem_req) begin
            timeouts++;
            $display("%s: load never reached the data memory", test_name);
        end
        backend_flush = 1'b1;
        step_cycle();
        backend_flush = 1'b0;
        run_op(MEM_SW, addr_list[4], $random(seed));
        run_op(MEM_LW, addr_list[4], '0);
        run_op(MEM_LB, addr_list[4] + 3, '0);
        run_op(MEM_LHU, addr_list[5] + 2, '0);
        wait_drain();
        repeat (10) step_cycle();

        $display("Errors: value %0d, protocol %0d, timeout %0d",
                 value_errs, other_errs, timeouts);
        if (value_errs + other_errs + timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
rtl/lsu_pkg.sv
rtl/lsu_agu.sv
rtl/lsu_queue.sv
rtl/lsu_data_mem.sv
rtl/lsu_top.sv
testbench/tb_lsu.sv

//--- Makefile
# Verilator build and run of the LSU testbench

TOP := tb_lsu

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f -o V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
